//--- src/lc3b_types.sv
package lc3b_types;

    // datapath word and register index
    typedef logic [15:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;

    // full lc3b opcode space
    // only add, and, not execute, the rest decode to no-ops
    typedef enum logic [3:0] {
        op_br   = 4'd0,
        op_add  = 4'd1,
        op_ldb  = 4'd2,
        op_stb  = 4'd3,
        op_jsr  = 4'd4,
        op_and  = 4'd5,
        op_ldr  = 4'd6,
        op_str  = 4'd7,
        op_rti  = 4'd8,
        op_not  = 4'd9,
        op_ldi  = 4'd10,
        op_sti  = 4'd11,
        op_jmp  = 4'd12,
        op_shf  = 4'd13,
        op_lea  = 4'd14,
        op_trap = 4'd15
    } lc3b_opcode;

    // control word carried through every barrier
    typedef struct packed {
        lc3b_opcode opcode;
        logic       regfile_load;
        lc3b_reg    regfile_dest;
        lc3b_reg    regfile_sr1;
        lc3b_reg    regfile_sr2;
        logic       requires_sr1;
        logic       requires_sr2;
        logic       use_imm;
        // sign-extended in EX
        logic [4:0] imm5;
    } lc3b_control_word;

    // operand source select for EX
    typedef enum logic [1:0] {
        lc3b_forward_mux_sel_pass                  = 2'd0,
        lc3b_forward_mux_sel_stage_MEM_regfile_data = 2'd1,
        lc3b_forward_mux_sel_stage_WB_regfile_data  = 2'd2
    } lc3b_forward_mux_sel;

    // program store geometry
    localparam int prog_depth = 8;
    localparam int prog_idx_w = 3;

    // apb byte address map, word stride 4
    localparam logic [7:0] prog_base   = 8'h00;
    localparam logic [7:0] ctrl_addr   = 8'h20;
    localparam logic [7:0] status_addr = 8'h24;
    localparam logic [7:0] reg_base    = 8'h40;

endpackage : lc3b_types

//--- src/lc3b_decode.sv
module lc3b_decode
    import lc3b_types::*;
(
    input  lc3b_word         instr,
    input  logic             valid,
    output lc3b_control_word ctrl
);

    lc3b_opcode opcode;
    logic       imm_flag;

    assign opcode   = lc3b_opcode'(instr[15:12]);
    assign imm_flag = instr[5];

    always_comb begin
        // empty slot decodes to an all-zero word
        ctrl = '0;

        if (valid) begin
            // raw field split
            ctrl.opcode       = opcode;
            ctrl.regfile_dest = instr[11:9];
            ctrl.regfile_sr1  = instr[8:6];
            ctrl.regfile_sr2  = instr[2:0];
            ctrl.imm5         = instr[4:0];

            unique case (opcode)
                op_add,
                op_and: begin
                    ctrl.regfile_load = 1'b1;
                    ctrl.requires_sr1 = 1'b1;
                    // sr2 only matters in register form
                    ctrl.requires_sr2 = ~imm_flag;
                    ctrl.use_imm      = imm_flag;
                end

                op_not: begin
                    // complement of sr1, sr2 field ignored
                    ctrl.regfile_load = 1'b1;
                    ctrl.requires_sr1 = 1'b1;
                end

                default: begin
                    // no-op, nothing written and nothing read
                    ctrl.regfile_load = 1'b0;
                    ctrl.requires_sr1 = 1'b0;
                    ctrl.requires_sr2 = 1'b0;
                    ctrl.use_imm      = 1'b0;
                end
            endcase
        end
    end

endmodule : lc3b_decode

//--- src/lc3b_regfile.sv
module lc3b_regfile
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     wr_en,
    input  lc3b_reg  wr_idx,
    input  lc3b_word wr_data,
    input  lc3b_reg  rd1_idx,
    input  lc3b_reg  rd2_idx,
    input  lc3b_reg  host_idx,
    output lc3b_word rd1_data,
    output lc3b_word rd2_data,
    output lc3b_word host_data
);

    lc3b_word regs [8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // write-through, ID sees the value WB writes this cycle
    assign rd1_data = (wr_en && wr_idx == rd1_idx) ? wr_data : regs[rd1_idx];
    assign rd2_data = (wr_en && wr_idx == rd2_idx) ? wr_data : regs[rd2_idx];

    // host view is the committed state
    assign host_data = regs[host_idx];

endmodule : lc3b_regfile

//--- src/forwarding_controller.sv
module forwarding_controller
    import lc3b_types::*;
(
    input  lc3b_control_word    barrier_ID_EX_control,
    input  lc3b_control_word    barrier_EX_MEM_control,
    input  lc3b_control_word    barrier_MEM_WB_control,
    output lc3b_forward_mux_sel forward_A_mux_sel,
    output lc3b_forward_mux_sel forward_B_mux_sel
);

    // hazard hits per barrier and operand
    logic ex_mem_hit_sr1;
    logic ex_mem_hit_sr2;
    logic mem_wb_hit_sr1;
    logic mem_wb_hit_sr2;

    always_comb begin
        // distance one, producer sits in EX/MEM
        ex_mem_hit_sr1 = barrier_EX_MEM_control.regfile_load &&
                         barrier_ID_EX_control.requires_sr1 &&
                         (barrier_ID_EX_control.regfile_sr1 ==
                          barrier_EX_MEM_control.regfile_dest);
        ex_mem_hit_sr2 = barrier_EX_MEM_control.regfile_load &&
                         barrier_ID_EX_control.requires_sr2 &&
                         (barrier_ID_EX_control.regfile_sr2 ==
                          barrier_EX_MEM_control.regfile_dest);

        // distance two, producer sits in MEM/WB
        mem_wb_hit_sr1 = barrier_MEM_WB_control.regfile_load &&
                         barrier_ID_EX_control.requires_sr1 &&
                         (barrier_ID_EX_control.regfile_sr1 ==
                          barrier_MEM_WB_control.regfile_dest);
        mem_wb_hit_sr2 = barrier_MEM_WB_control.regfile_load &&
                         barrier_ID_EX_control.requires_sr2 &&
                         (barrier_ID_EX_control.regfile_sr2 ==
                          barrier_MEM_WB_control.regfile_dest);

        // newest result wins, EX/MEM checked first
        if (ex_mem_hit_sr1) begin
            forward_A_mux_sel = lc3b_forward_mux_sel_stage_MEM_regfile_data;
        end else if (mem_wb_hit_sr1) begin
            forward_A_mux_sel = lc3b_forward_mux_sel_stage_WB_regfile_data;
        end else begin
            forward_A_mux_sel = lc3b_forward_mux_sel_pass;
        end

        if (ex_mem_hit_sr2) begin
            forward_B_mux_sel = lc3b_forward_mux_sel_stage_MEM_regfile_data;
        end else if (mem_wb_hit_sr2) begin
            forward_B_mux_sel = lc3b_forward_mux_sel_stage_WB_regfile_data;
        end else begin
            forward_B_mux_sel = lc3b_forward_mux_sel_pass;
        end
    end

endmodule : forwarding_controller

//--- src/lc3b_alu_stage.sv
module lc3b_alu_stage
    import lc3b_types::*;
(
    input  lc3b_control_word    ctrl,
    input  lc3b_word            sr1_data,
    input  lc3b_word            sr2_data,
    input  lc3b_word            mem_data,
    input  lc3b_word            wb_data,
    input  lc3b_forward_mux_sel forward_A_mux_sel,
    input  lc3b_forward_mux_sel forward_B_mux_sel,
    output lc3b_word            result
);

    lc3b_word op_a;
    lc3b_word op_b_fwd;
    lc3b_word op_b;
    lc3b_word imm_sext;

    always_comb begin
        // operand A source
        unique case (forward_A_mux_sel)
            lc3b_forward_mux_sel_stage_MEM_regfile_data: op_a = mem_data;
            lc3b_forward_mux_sel_stage_WB_regfile_data:  op_a = wb_data;
            default:                                     op_a = sr1_data;
        endcase

        // operand B source
        unique case (forward_B_mux_sel)
            lc3b_forward_mux_sel_stage_MEM_regfile_data: op_b_fwd = mem_data;
            lc3b_forward_mux_sel_stage_WB_regfile_data:  op_b_fwd = wb_data;
            default:                                     op_b_fwd = sr2_data;
        endcase

        // imm5 overrides B in immediate form
        imm_sext = {{11{ctrl.imm5[4]}}, ctrl.imm5};
        op_b     = ctrl.use_imm ? imm_sext : op_b_fwd;

        case (ctrl.opcode)
            op_add:  result = op_a + op_b;
            op_and:  result = op_a & op_b;
            op_not:  result = ~op_a;
            // no-op, never written back
            default: result = '0;
        endcase
    end

endmodule : lc3b_alu_stage

//--- src/lc3b_pipeline.sv
module lc3b_pipeline
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     issue_valid,
    input  lc3b_word issue_instr,
    input  lc3b_reg  host_reg_idx,
    output lc3b_word host_reg_data,
    output logic     retire_valid
);

    // ID stage
    lc3b_control_word id_ctrl;
    lc3b_word         id_sr1_data;
    lc3b_word         id_sr2_data;

    // ID/EX barrier
    logic             id_ex_valid;
    lc3b_control_word id_ex_ctrl;
    lc3b_word         id_ex_sr1_data;
    lc3b_word         id_ex_sr2_data;

    // EX/MEM barrier
    logic             ex_mem_valid;
    lc3b_control_word ex_mem_ctrl;
    lc3b_word         ex_mem_result;

    // MEM/WB barrier
    logic             mem_wb_valid;
    lc3b_control_word mem_wb_ctrl;
    lc3b_word         mem_wb_result;

    // valid-gated views of the barrier words
    lc3b_control_word id_ex_ctrl_v;
    lc3b_control_word ex_mem_ctrl_v;
    lc3b_control_word mem_wb_ctrl_v;

    lc3b_forward_mux_sel forward_A_mux_sel;
    lc3b_forward_mux_sel forward_B_mux_sel;
    lc3b_word            ex_result;

    lc3b_decode u_decode (
        .instr (issue_instr),
        .valid (issue_valid),
        .ctrl  (id_ctrl)
    );

    // operands read in ID, WB write bypassed inside
    lc3b_regfile u_regfile (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (mem_wb_ctrl_v.regfile_load),
        .wr_idx    (mem_wb_ctrl_v.regfile_dest),
        .wr_data   (mem_wb_result),
        .rd1_idx   (id_ctrl.regfile_sr1),
        .rd2_idx   (id_ctrl.regfile_sr2),
        .host_idx  (host_reg_idx),
        .rd1_data  (id_sr1_data),
        .rd2_data  (id_sr2_data),
        .host_data (host_reg_data)
    );

    // an empty slot never loads
    always_comb begin
        id_ex_ctrl_v                = id_ex_ctrl;
        id_ex_ctrl_v.regfile_load   = id_ex_ctrl.regfile_load & id_ex_valid;
        ex_mem_ctrl_v               = ex_mem_ctrl;
        ex_mem_ctrl_v.regfile_load  = ex_mem_ctrl.regfile_load & ex_mem_valid;
        mem_wb_ctrl_v               = mem_wb_ctrl;
        mem_wb_ctrl_v.regfile_load  = mem_wb_ctrl.regfile_load & mem_wb_valid;
    end

    forwarding_controller u_forwarding_controller (
        .barrier_ID_EX_control  (id_ex_ctrl_v),
        .barrier_EX_MEM_control (ex_mem_ctrl_v),
        .barrier_MEM_WB_control (mem_wb_ctrl_v),
        .forward_A_mux_sel      (forward_A_mux_sel),
        .forward_B_mux_sel      (forward_B_mux_sel)
    );

    lc3b_alu_stage u_alu_stage (
        .ctrl              (id_ex_ctrl_v),
        .sr1_data          (id_ex_sr1_data),
        .sr2_data          (id_ex_sr2_data),
        .mem_data          (ex_mem_result),
        .wb_data           (mem_wb_result),
        .forward_A_mux_sel (forward_A_mux_sel),
        .forward_B_mux_sel (forward_B_mux_sel),
        .result            (ex_result)
    );

    // barrier control, no stalls so every stage advances each cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex_valid  <= 1'b0;
            id_ex_ctrl   <= '0;
            ex_mem_valid <= 1'b0;
            ex_mem_ctrl  <= '0;
            mem_wb_valid <= 1'b0;
            mem_wb_ctrl  <= '0;
        end else begin
            id_ex_valid  <= issue_valid;
            id_ex_ctrl   <= id_ctrl;
            ex_mem_valid <= id_ex_valid;
            ex_mem_ctrl  <= id_ex_ctrl;
            mem_wb_valid <= ex_mem_valid;
            mem_wb_ctrl  <= ex_mem_ctrl;
        end
    end

    // barrier payload
    always_ff @(posedge clk) begin
        id_ex_sr1_data <= id_sr1_data;
        id_ex_sr2_data <= id_sr2_data;
        ex_mem_result  <= ex_result;
        // MEM passes the result through
        mem_wb_result  <= ex_mem_result;
    end

    assign retire_valid = mem_wb_valid;

endmodule : lc3b_pipeline

//--- src/lc3b_apb_sequencer.sv
module lc3b_apb_sequencer
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     psel,
    input  logic     penable,
    input  logic     pwrite,
    input  logic [7:0] paddr,
    input  lc3b_word pwdata,
    output lc3b_word prdata,
    output logic     pready,
    output logic     pslverr,
    input  logic     retire_valid,
    input  lc3b_word host_reg_data,
    output logic     issue_valid,
    output lc3b_word issue_instr,
    output lc3b_reg  host_reg_idx
);

    lc3b_word prog_mem [prog_depth];

    logic                  busy;
    logic                  issuing;
    logic [prog_idx_w-1:0] issue_idx;
    logic [prog_idx_w-1:0] run_last;
    logic [prog_idx_w-1:0] retire_cnt;

    logic                  access;
    logic [7:0]            prog_off;
    logic [7:0]            reg_off;
    logic [prog_idx_w-1:0] prog_idx;
    logic                  hit_prog;
    logic                  hit_ctrl;
    logic                  hit_status;
    logic                  hit_reg;
    logic                  count_bad;
    logic                  err;
    logic                  prog_we;
    logic                  start;

    always_comb begin
        access   = psel & penable;
        prog_off = paddr - prog_base;
        reg_off  = paddr - reg_base;
        prog_idx = prog_off[prog_idx_w+1:2];

        // word-aligned windows only
        hit_prog   = (paddr[1:0] == 2'b00) && (paddr >= prog_base) &&
                     (prog_off < 8'(4 * prog_depth));
        hit_reg    = (paddr[1:0] == 2'b00) && (paddr >= reg_base) &&
                     (reg_off < 8'(4 * (2 ** $bits(lc3b_reg))));
        hit_ctrl   = (paddr == ctrl_addr);
        hit_status = (paddr == status_addr);

        // count must be 1 to prog_depth
        count_bad = (pwdata == '0) || (pwdata > lc3b_word'(prog_depth));

        err = ~(hit_prog | hit_ctrl | hit_status | hit_reg);
        if (pwrite && busy && (hit_prog || hit_ctrl)) begin
            err = 1'b1;
        end
        if (pwrite && hit_ctrl && count_bad) begin
            err = 1'b1;
        end

        prog_we = access & pwrite & hit_prog & ~err;
        start   = access & pwrite & hit_ctrl & ~err;
    end

    // zero wait states
    assign pready  = 1'b1;
    assign pslverr = access & err;

    assign host_reg_idx = reg_off[$bits(lc3b_reg)+1:2];

    // read mux, status and regs always visible
    always_comb begin
        if (hit_prog) begin
            prdata = prog_mem[prog_idx];
        end else if (hit_ctrl) begin
            prdata = lc3b_word'({1'b0, run_last}) + 16'd1;
        end else if (hit_status) begin
            prdata = {15'b0, busy};
        end else if (hit_reg) begin
            prdata = host_reg_data;
        end else begin
            prdata = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_mem    <= '{default: '0};
            busy        <= 1'b0;
            issuing     <= 1'b0;
            issue_valid <= 1'b0;
            issue_idx   <= '0;
            run_last    <= '0;
            retire_cnt  <= '0;
        end else begin
            if (prog_we) begin
                prog_mem[prog_idx] <= pwdata;
            end

            // slot goes out one cycle after its index
            issue_valid <= issuing;

            if (start) begin
                busy       <= 1'b1;
                issuing    <= 1'b1;
                issue_idx  <= '0;
                retire_cnt <= '0;
                run_last   <= prog_idx_w'(pwdata - 16'd1);
            end else begin
                if (issuing) begin
                    if (issue_idx == run_last) begin
                        issuing <= 1'b0;
                    end else begin
                        issue_idx <= issue_idx + 1'b1;
                    end
                end

                // busy drops with the last write
                if (busy && retire_valid) begin
                    if (retire_cnt == run_last) begin
                        busy <= 1'b0;
                    end else begin
                        retire_cnt <= retire_cnt + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        issue_instr <= prog_mem[issue_idx];
    end

endmodule : lc3b_apb_sequencer

//--- src/lc3b_pipe_top.sv
module lc3b_pipe_top
    import lc3b_types::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [7:0] paddr,
    input  lc3b_word   pwdata,
    output lc3b_word   prdata,
    output logic       pready,
    output logic       pslverr
);

    // sequencer to pipeline
    logic     issue_valid;
    lc3b_word issue_instr;
    logic     retire_valid;
    lc3b_reg  host_reg_idx;
    lc3b_word host_reg_data;

    lc3b_apb_sequencer u_apb_sequencer (
        .clk           (clk),
        .arst_n        (arst_n),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .retire_valid  (retire_valid),
        .host_reg_data (host_reg_data),
        .issue_valid   (issue_valid),
        .issue_instr   (issue_instr),
        .host_reg_idx  (host_reg_idx)
    );

    lc3b_pipeline u_pipeline (
        .clk           (clk),
        .arst_n        (arst_n),
        .issue_valid   (issue_valid),
        .issue_instr   (issue_instr),
        .host_reg_idx  (host_reg_idx),
        .host_reg_data (host_reg_data),
        .retire_valid  (retire_valid)
    );

endmodule : lc3b_pipe_top

//--- verif/lc3b_pipe_asserts.sv
module lc3b_pipe_asserts #(
    parameter bit check_fwd = 1'b1,
    parameter bit check_apb = 1'b1
) (
    input logic       clk,
    input logic       arst_n,
    input logic [1:0] fwd_a_sel,
    input logic [1:0] fwd_b_sel,
    input logic       psel,
    input logic       penable,
    input logic       pslverr,
    input logic       busy,
    input logic       issue_valid
);

    // read back by the testbench at the end of the run
    int unsigned fail_count = 0;

    if (check_fwd) begin : g_fwd
        // both operand selects resolve every cycle
        fwd_sel_known: assert property (@(posedge clk) disable iff (!arst_n)
            !$isunknown({fwd_a_sel, fwd_b_sel}))
            else begin
                $error("forward select is unknown");
                fail_count++;
            end
    end

    if (check_apb) begin : g_apb
        // slave error only in the access phase
        slverr_in_access: assert property (@(posedge clk) disable iff (!arst_n)
            pslverr |-> (psel && penable))
            else begin
                $error("pslverr raised outside an access cycle");
                fail_count++;
            end

        // no slot goes out while idle
        issue_needs_busy: assert property (@(posedge clk) disable iff (!arst_n)
            !busy |-> !issue_valid)
            else begin
                $error("issue_valid high while not busy");
                fail_count++;
            end
    end

endmodule : lc3b_pipe_asserts

// pipeline copy checks only the forward selects
bind lc3b_pipeline lc3b_pipe_asserts #(
    .check_fwd (1'b1),
    .check_apb (1'b0)
) u_pipe_asserts (
    .clk         (clk),
    .arst_n      (arst_n),
    .fwd_a_sel   (forward_A_mux_sel),
    .fwd_b_sel   (forward_B_mux_sel),
    .psel        (1'b0),
    .penable     (1'b0),
    .pslverr     (1'b0),
    .busy        (1'b0),
    .issue_valid (1'b0)
);

// sequencer copy watches APB and the issue slot
bind lc3b_apb_sequencer lc3b_pipe_asserts #(
    .check_fwd (1'b0),
    .check_apb (1'b1)
) u_seq_asserts (
    .clk         (clk),
    .arst_n      (arst_n),
    .fwd_a_sel   (2'b00),
    .fwd_b_sel   (2'b00),
    .psel        (psel),
    .penable     (penable),
    .pslverr     (pslverr),
    .busy        (busy),
    .issue_valid (issue_valid)
);

//--- verif/tb_lc3b_pipe.sv
module tb_lc3b_pipe
    import lc3b_types::*;
();

    logic       clk;
    logic       arst_n;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [7:0] paddr;
    lc3b_word   pwdata;
    lc3b_word   prdata;
    logic       pready;
    logic       pslverr;

    // reference register file and the program image last loaded
    lc3b_word    model [8];
    lc3b_word    prog [prog_depth];
    logic [31:0] lfsr_state;
    int          value_errs;
    int          other_errs;
    int unsigned assert_errs;
    int          test_total = 6;

    lc3b_pipe_top u_lc3b_pipe_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #20 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [4:0] rand_bits(input int nbits);
        logic [4:0] v;
        logic       fb;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[3:0], fb};
        end
        return v;
    endfunction

    // imm5 whose low three bits name a register
    function automatic logic [4:0] imm_over_reg(input lc3b_reg idx);
        logic [4:0] hi;
        hi = rand_bits(2);
        return {hi[1:0], idx};
    endfunction

    // instruction encoders
    function automatic lc3b_word enc_reg(input lc3b_opcode op, input lc3b_reg dr,
                                         input lc3b_reg sr1, input lc3b_reg sr2);
        return {op, dr, sr1, 3'b000, sr2};
    endfunction

    function automatic lc3b_word enc_imm(input lc3b_opcode op, input lc3b_reg dr,
                                         input lc3b_reg sr1, input logic [4:0] imm);
        return {op, dr, sr1, 1'b1, imm};
    endfunction

    // junk lands in the sr2 field
    function automatic lc3b_word enc_not(input lc3b_reg dr, input lc3b_reg sr,
                                         input lc3b_reg junk);
        return {op_not, dr, sr, 3'b111, junk};
    endfunction

    // architectural effect of one instruction
    task automatic apply_model(input lc3b_word instr);
        lc3b_word a;
        lc3b_word b;
        a = model[instr[8:6]];
        b = instr[5] ? {{11{instr[4]}}, instr[4:0]} : model[instr[2:0]];
        case (lc3b_opcode'(instr[15:12]))
            op_add:  model[instr[11:9]] = a + b;
            op_and:  model[instr[11:9]] = a & b;
            op_not:  model[instr[11:9]] = ~a;
            default: ;
        endcase
    endtask

    task automatic check_word(input string name, input lc3b_word exp, input lc3b_word act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, act);
            value_errs++;
        end
    endtask

    // setup, access, sample mid access, release on completion
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input lc3b_word wdata, output lc3b_word rdata,
                                output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        // zero wait states, every access completes at once
        check_flag("pready", 1'b1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input lc3b_word data, output logic err);
        lc3b_word unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output lc3b_word data, output logic err);
        apb_transfer(1'b0, addr, 16'h0000, data, err);
    endtask

    task automatic load_program(input int count);
        logic err;
        for (int i = 0; i < count; i++) begin
            apb_write(prog_base + 8'(4 * i), prog[i], err);
            check_flag("pslverr", 1'b0, err);
        end
    endtask

    task automatic start_run(input int count);
        logic err;
        apb_write(ctrl_addr, lc3b_word'(count), err);
        check_flag("pslverr", 1'b0, err);
    endtask

    // poll status until busy clears
    task automatic wait_idle();
        lc3b_word rd;
        logic     err;
        int       polls;
        polls = 0;
        rd    = 16'h0001;
        while (rd[0] && polls < 64) begin
            apb_read(status_addr, rd, err);
            polls++;
        end
        if (rd[0]) begin
            $display("pipeline still busy after %0d status polls", polls);
            other_errs++;
        end
    endtask

    task automatic check_regs();
        lc3b_word rd;
        logic     err;
        for (int n = 0; n < 8; n++) begin
            apb_read(reg_base + 8'(4 * n), rd, err);
            check_flag("pslverr", 1'b0, err);
            check_word($sformatf("r%0d", n), model[n], rd);
        end
    endtask

    task automatic finish_run(input int count);
        wait_idle();
        for (int i = 0; i < count; i++) begin
            apply_model(prog[i]);
        end
        check_regs();
    endtask

    task automatic run_and_check(input int count);
        load_program(count);
        start_run(count);
        finish_run(count);
    endtask

    task automatic test_reset_state();
        lc3b_word rd;
        logic     err;
        check_regs();
        apb_read(status_addr, rd, err);
        check_word("status", 16'h0000, rd);
    endtask

    // no producer within distance three of its consumer
    task automatic test_independent_ops();
        prog[0] = enc_imm(op_add, 3'd1, 3'd0, rand_bits(5));
        prog[1] = enc_imm(op_add, 3'd2, 3'd0, rand_bits(5));
        prog[2] = enc_imm(op_add, 3'd3, 3'd0, rand_bits(5));
        prog[3] = enc_imm(op_add, 3'd4, 3'd0, rand_bits(5));
        // lea writes nothing here
        prog[4] = enc_imm(op_lea, 3'd1, 3'd0, 5'h1f);
        prog[5] = enc_reg(op_and, 3'd5, 3'd1, 3'd2);
        prog[6] = enc_not(3'd6, 3'd3, 3'd0);
        prog[7] = enc_imm(op_and, 3'd7, 3'd4, rand_bits(5));
        run_and_check(8);
    endtask

    // each step reads the previous destination on both operands
    task automatic test_forward_chain();
        prog[0] = enc_imm(op_add, 3'd1, 3'd0, rand_bits(5) | 5'd1);
        prog[1] = enc_reg(op_add, 3'd2, 3'd1, 3'd1);
        prog[2] = enc_reg(op_add, 3'd3, 3'd2, 3'd2);
        prog[3] = enc_reg(op_and, 3'd4, 3'd3, 3'd3);
        prog[4] = enc_reg(op_add, 3'd5, 3'd4, 3'd4);
        prog[5] = enc_not(3'd6, 3'd5, 3'd5);
        prog[6] = enc_reg(op_add, 3'd7, 3'd6, 3'd6);
        prog[7] = enc_reg(op_add, 3'd1, 3'd7, 3'd7);
        run_and_check(8);
    endtask

    task automatic test_far_dependencies();
        prog[0] = enc_imm(op_add, 3'd1, 3'd0, rand_bits(5));
        prog[1] = enc_imm(op_add, 3'd2, 3'd0, rand_bits(5));
        prog[2] = 16'h0000;
        // r1 at distance 3 through the bypass, r2 at distance 2
        prog[3] = enc_reg(op_add, 3'd3, 3'd1, 3'd2);
        prog[4] = enc_imm(op_add, 3'd5, 3'd0, rand_bits(5));
        prog[5] = enc_imm(op_add, 3'd5, 3'd3, rand_bits(5));
        // r5 written at distances 1 and 2, newer one wins
        prog[6] = enc_reg(op_add, 3'd6, 3'd5, 3'd5);
        prog[7] = enc_reg(op_add, 3'd7, 3'd5, 3'd6);
        run_and_check(8);
    endtask

    // sr2 field aliases a register in flight
    task automatic test_stale_sr2();
        prog[0] = enc_imm(op_add, 3'd2, 3'd0, rand_bits(5));
        prog[1] = enc_imm(op_add, 3'd3, 3'd1, imm_over_reg(3'd2));
        prog[2] = enc_not(3'd4, 3'd1, 3'd2);
        prog[3] = enc_imm(op_and, 3'd5, 3'd4, imm_over_reg(3'd3));
        prog[4] = enc_imm(op_add, 3'd6, 3'd0, rand_bits(5));
        prog[5] = enc_not(3'd7, 3'd3, 3'd6);
        prog[6] = enc_imm(op_add, 3'd1, 3'd7, imm_over_reg(3'd6));
        prog[7] = enc_not(3'd2, 3'd6, 3'd7);
        run_and_check(8);
    endtask

    task automatic test_error_responses();
        lc3b_word rd;
        logic     err;
        // unmapped and misaligned
        apb_read(8'h60, rd, err);
        check_flag("pslverr", 1'b1, err);
        apb_write(8'h28, 16'hffff, err);
        check_flag("pslverr", 1'b1, err);
        apb_write(8'h02, 16'hffff, err);
        check_flag("pslverr", 1'b1, err);
        // accumulating program, a corrupted word would show on rerun
        prog[0] = enc_imm(op_add, 3'd1, 3'd1, rand_bits(5) | 5'd1);
        prog[1] = enc_reg(op_add, 3'd2, 3'd2, 3'd1);
        prog[2] = enc_imm(op_and, 3'd3, 3'd2, rand_bits(5));
        prog[3] = enc_not(3'd4, 3'd3, 3'd1);
        prog[4] = enc_reg(op_add, 3'd5, 3'd4, 3'd2);
        prog[5] = enc_reg(op_and, 3'd6, 3'd5, 3'd1);
        prog[6] = enc_imm(op_add, 3'd7, 3'd6, rand_bits(5));
        prog[7] = enc_reg(op_add, 3'd1, 3'd1, 3'd7);
        load_program(8);
        start_run(8);
        // ADD r7, r0, #-1 must not land while busy
        apb_write(prog_base, 16'h1e3f, err);
        check_flag("pslverr", 1'b1, err);
        apb_write(ctrl_addr, 16'd2, err);
        check_flag("pslverr", 1'b1, err);
        finish_run(8);
        // count out of range starts nothing
        apb_write(ctrl_addr, 16'd0, err);
        check_flag("pslverr", 1'b1, err);
        apb_read(status_addr, rd, err);
        check_word("status", 16'h0000, rd);
        apb_write(ctrl_addr, 16'd9, err);
        check_flag("pslverr", 1'b1, err);
        apb_read(status_addr, rd, err);
        check_word("status", 16'h0000, rd);
        // rerun the stored program untouched
        start_run(8);
        finish_run(8);
    endtask

    initial begin
        repeat (test_total * 400) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not complete", test_total * 400);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr_state = 32'h853;
        value_errs = 0;
        other_errs = 0;
        model      = '{default: '0};
        prog       = '{default: '0};
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        test_reset_state();
        test_independent_ops();
        test_forward_chain();
        test_far_dependencies();
        test_stale_sr2();
        test_error_responses();

        assert_errs = u_lc3b_pipe_top.u_pipeline.u_pipe_asserts.fail_count +
                      u_lc3b_pipe_top.u_apb_sequencer.u_seq_asserts.fail_count;
        $display("errors: value %0d, other %0d, assertion %0d",
                 value_errs, other_errs, assert_errs);
        if (value_errs == 0 && other_errs == 0 && assert_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : tb_lc3b_pipe

//--- project.f
src/lc3b_types.sv
src/lc3b_decode.sv
src/lc3b_regfile.sv
src/forwarding_controller.sv
src/lc3b_alu_stage.sv
src/lc3b_pipeline.sv
src/lc3b_apb_sequencer.sv
src/lc3b_pipe_top.sv
verif/lc3b_pipe_asserts.sv
verif/tb_lc3b_pipe.sv
